// File: Makefile
# Verilator build and run for the DP RX link symbol path

VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = tb_dprx_lnk
FILELIST  = build.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
dprx_pkg.sv
lnk_lane_if.sv
dprx_ctl.sv
dprx_pars.sv
dprx_scrm.sv
dprx_lnk.sv
tb_dprx_lnk.sv

// File: dprx_ctl.sv
/*
    DP RX link control
    Decodes the control message into lane and scrambler enables
    and combines the per-lane locks into the link lock
*/
`timescale 1ns/100ps

module dprx_ctl
#(
    parameter int P_LANES = 4                   // Lanes in this build
)
(
    input  logic                LNK_CLK_IN,
    input  logic                reset,
    input  logic                msg_som,
    input  logic                msg_eom,
    input  logic                msg_vld,
    input  dprx_pkg::msg_dat_t  msg_dat,
    input  logic [P_LANES-1:0]  lane_lock,      // From the descramblers
    output logic [P_LANES-1:0]  lane_en,
    output logic                scrm_en,
    output logic                lnk_lock
);
    import dprx_pkg::*;

    ctl_state_t             state;
    lanes_t                 lanes_fld;          // Lane count field of the control word
    logic [MAX_LANES-1:0]   lane_mask;          // Decoded enable mask
    logic [MAX_LANES-1:0]   lane_en_r;

    assign lanes_fld = lanes_t'(msg_dat[2:1]);

    // Lane count to mask gated by link enable
    always_comb
    begin
        case (lanes_fld)
            lanes_1 : lane_mask = MAX_LANES'(1);
            lanes_2 : lane_mask = MAX_LANES'(3);
            lanes_4 : lane_mask = MAX_LANES'(15);
            default : lane_mask = '0;           // No lanes
        endcase
        lane_mask = lane_mask & {MAX_LANES{msg_dat[0]}};
    end

    // Message decoder
    always_ff @(posedge LNK_CLK_IN)
    begin
        if (reset)
        begin
            state     <= idle;
            lane_en_r <= '0;
            scrm_en   <= 1'b0;
        end
        else if (msg_vld)
        begin
            // Any start of message restarts the match
            if (msg_som)
                state <= (msg_dat == MSG_ID_CTL && !msg_eom) ? wait_data : idle;
            else if (state == wait_data && msg_eom)
            begin
                lane_en_r <= lane_mask;         // Config takes effect next cycle
                scrm_en   <= msg_dat[3];
                state     <= idle;
            end
        end
    end

    assign lane_en = lane_en_r[P_LANES-1:0];

    // Unused lanes count as locked for the link lock
    always_ff @(posedge LNK_CLK_IN)
    begin
        if (reset)
            lnk_lock <= 1'b0;
        else
            lnk_lock <= (|lane_en) && (&(lane_lock | ~lane_en));
    end

    // Mask never reaches a lane that is not built
    a_lane_range : assert property (@(posedge LNK_CLK_IN) disable iff (reset)
        (lane_en_r >> P_LANES) == '0)
        else $error("lane enable set above P_LANES");

endmodule

// File: dprx_lnk.sv
/*
    DP RX link layer symbol path
    Control decoder, one parser and one descrambler per lane
*/
`timescale 1ns/100ps

module dprx_lnk
#(
    parameter int P_LANES = 4                   // 1, 2 or 4
)
(
    input  logic                    LNK_CLK_IN,
    input  logic                    reset,

    // Message input
    input  logic                    msg_som,
    input  logic                    msg_eom,
    input  logic                    msg_vld,
    input  dprx_pkg::msg_dat_t      msg_dat,

    // Link symbols in, lane i on bits i*8 and up
    input  logic [P_LANES-1:0]      in_k,
    input  logic [P_LANES*8-1:0]    in_dat,

    // Descrambled symbols out, two cycles later
    output logic [P_LANES-1:0]      lnk_k,
    output logic [P_LANES*8-1:0]    lnk_dat,
    output logic                    lnk_sync,
    output logic                    lnk_lock
);

    logic [P_LANES-1:0] lane_en;                // Active lane mask
    logic [P_LANES-1:0] lane_lock;              // Per-lane lock back to control
    logic [P_LANES-1:0] lane_sync;              // Delayed BE markers
    logic               scrm_en;

    dprx_ctl
    #(
        .P_LANES        (P_LANES)
    )
    ctl_i
    (
        .LNK_CLK_IN     (LNK_CLK_IN),
        .reset          (reset),
        .msg_som        (msg_som),
        .msg_eom        (msg_eom),
        .msg_vld        (msg_vld),
        .msg_dat        (msg_dat),
        .lane_lock      (lane_lock),
        .lane_en        (lane_en),
        .scrm_en        (scrm_en),
        .lnk_lock       (lnk_lock)
    );

    genvar i;

    generate
        for (i = 0; i < P_LANES; i++)
        begin : gen_lane
            lnk_lane_if lane_if ();             // Parser to descrambler

            dprx_pars pars_i
            (
                .LNK_CLK_IN (LNK_CLK_IN),
                .reset      (reset),
                .lane_en    (lane_en[i]),
                .sym_k      (in_k[i]),
                .sym_dat    (in_dat[i*8 +: 8]),
                .lane       (lane_if.src)
            );

            dprx_scrm scrm_i
            (
                .LNK_CLK_IN (LNK_CLK_IN),
                .reset      (reset),
                .scrm_en    (scrm_en),
                .lane       (lane_if.snk),
                .out_k      (lnk_k[i]),
                .out_dat    (lnk_dat[i*8 +: 8]),
                .out_sync   (lane_sync[i]),
                .lane_lock  (lane_lock[i])
            );
        end
    endgenerate

    // Line sync follows lane 0
    assign lnk_sync = lane_sync[0];

endmodule

// File: dprx_pars.sv
/*
    DP RX lane parser
    Registers the lane symbol, flags SR and BE, and tracks lane lock
*/
`timescale 1ns/100ps

module dprx_pars
(
    input  logic            LNK_CLK_IN,
    input  logic            reset,
    input  logic            lane_en,            // Lane is inside the active count
    input  logic            sym_k,
    input  dprx_pkg::sym_t  sym_dat,
    lnk_lane_if.src         lane
);
    import dprx_pkg::*;

    logic is_sr;
    logic is_be;

    // Control symbol match, byte alone is not enough
    assign is_sr = sym_k && (sym_dat == SYM_SR);
    assign is_be = sym_k && (sym_dat == SYM_BE);

    // Symbol byte, zero on a disabled lane
    always_ff @(posedge LNK_CLK_IN)
    begin
        lane.dat <= lane_en ? sym_dat : '0;
    end

    always_ff @(posedge LNK_CLK_IN)
    begin
        if (reset)
        begin
            lane.k    <= 1'b0;
            lane.sr   <= 1'b0;
            lane.be   <= 1'b0;
            lane.lock <= 1'b0;
        end
        else
        begin
            lane.k  <= lane_en && sym_k;
            lane.sr <= lane_en && is_sr;        // Reloads descrambler
            lane.be <= lane_en && is_be;        // Line sync source

            // Lock from first SR, lost when the lane is dropped
            if (!lane_en)
                lane.lock <= 1'b0;
            else if (is_sr)
                lane.lock <= 1'b1;
        end
    end

endmodule

// File: dprx_pkg.sv
/*
    DP RX link shared definitions
    Symbol codes, message IDs, lane count encoding and common widths
*/
package dprx_pkg;

    // Link symbols are one byte per lane per cycle
    typedef logic [7:0] sym_t;

    // Message words as they arrive on the message input
    typedef logic [15:0] msg_dat_t;

    // Widest link this block supports
    localparam int MAX_LANES = 4;

    // Control symbols, only valid with k set
    localparam sym_t SYM_BS = 8'hBC;            // K28.5 blanking start
    localparam sym_t SYM_BE = 8'hFB;            // K27.7 blanking end
    localparam sym_t SYM_SR = 8'h1C;            // K28.0 scrambler reset

    // Control message ID, first word of the message
    localparam msg_dat_t MSG_ID_CTL = 16'h0014;

    // Descrambler LFSR value after each SR
    localparam logic [15:0] LFSR_SEED = 16'hFFFF;

    // Active lanes field, bits 2:1 of the control word
    typedef enum logic [1:0]
    {
        lanes_none = 2'd0,                      // Link carries no lanes
        lanes_1    = 2'd1,
        lanes_2    = 2'd2,
        lanes_4    = 2'd3
    } lanes_t;

    // Control message decoder
    typedef enum logic
    {
        idle,                                   // Waiting for a start of message
        wait_data                               // ID matched, control word next
    } ctl_state_t;

endpackage

// File: dprx_scrm.sv
/*
    DP RX lane descrambler
    16-bit LFSR, x^16+x^5+x^4+x^3+1, reloaded on every SR symbol
*/
`timescale 1ns/100ps

module dprx_scrm
(
    input  logic            LNK_CLK_IN,
    input  logic            reset,
    input  logic            scrm_en,            // Scrambling on the link
    lnk_lane_if.snk         lane,
    output logic            out_k,
    output dprx_pkg::sym_t  out_dat,
    output logic            out_sync,           // BE marker, delayed with the data
    output logic            lane_lock
);
    import dprx_pkg::*;

    logic [15:0] lfsr;
    logic [15:0] lfsr_nxt;
    sym_t        key;                           // Key byte for the current symbol

    // Eight LFSR steps, bit 15 out first as key bit 0
    function automatic logic [23:0] lfsr_adv(input logic [15:0] seed);
        logic [15:0] s;
        logic [7:0]  k;
        s = seed;
        k = '0;
        for (int i = 0; i < 8; i++)
        begin
            k[i] = s[15];
            // Galois form, feedback into bits 0, 3, 4 and 5
            s = {s[14:0], 1'b0} ^ (s[15] ? 16'h0039 : 16'h0000);
        end
        return {k, s};
    endfunction

    assign {key, lfsr_nxt} = lfsr_adv(lfsr);

    // SR reloads, every other symbol advances a byte
    always_ff @(posedge LNK_CLK_IN)
    begin
        if (reset)
            lfsr <= LFSR_SEED;
        else if (lane.sr)
            lfsr <= LFSR_SEED;
        else
            lfsr <= lfsr_nxt;
    end

    // Data only, and only once the lane has seen an SR
    always_ff @(posedge LNK_CLK_IN)
    begin
        if (scrm_en && lane.lock && !lane.k)
            out_dat <= lane.dat ^ key;
        else
            out_dat <= lane.dat;                // K symbols pass unchanged
    end

    always_ff @(posedge LNK_CLK_IN)
    begin
        if (reset)
        begin
            out_k     <= 1'b0;
            out_sync  <= 1'b0;
            lane_lock <= 1'b0;
        end
        else
        begin
            out_k     <= lane.k;
            out_sync  <= lane.be;
            lane_lock <= lane.lock;
        end
    end

    // Parser flags one control symbol per cycle
    a_sr_be : assert property (@(posedge LNK_CLK_IN) disable iff (reset)
        !(lane.sr && lane.be))
        else $error("SR and BE flagged together");

endmodule

// File: lnk_cases.txt
# Columns: message ID (hex), lanes code 0-3, link enable, scrambler enable,
# symbol count, BE position on lane 0 (255 for no BE)
0014 3 1 1 20 7
0014 1 1 1 16 3
0014 2 1 1 16 10
0014 3 1 0 12 4
0014 0 1 1 10 2
0014 3 0 1 10 5
0014 2 1 0 14 255
0021 1 1 1 12 6
0014 3 1 1 24 0
0014 1 1 0 8 7
0000 0 0 0 10 3
0014 3 1 1 32 16
0014 2 1 1 12 255

// File: lnk_lane_if.sv
/*
    Single lane symbol stream
    Carries one symbol per cycle with its SR, BE and lock markers
*/
`timescale 1ns/100ps

interface lnk_lane_if;
    import dprx_pkg::*;

    logic k;                // Control symbol flag
    sym_t dat;              // Symbol byte
    logic sr;               // Scrambler reset seen
    logic be;               // Blanking end seen
    logic lock;             // Lane has seen SR while enabled

    // Parser side
    modport src
    (
        output k, dat, sr, be, lock
    );

    // Descrambler side
    modport snk
    (
        input k, dat, sr, be, lock
    );

endinterface

// File: tb_dprx_lnk.sv
/*
    Testbench for the DP RX link symbol path
    Reads cases from lnk_cases.txt, scrambles LCG plaintext with its own
    LFSR model and checks the descrambled lanes, lock and line sync
*/
`timescale 1ns/100ps

module tb_dprx_lnk;

    localparam int          LANES       = 4;
    localparam int          MAX_CASES   = 64;
    localparam int          LOCK_WINDOW = 5;        // Steps from SR to link lock
    localparam int          FLUSH       = 3;        // Idle steps to drain the pipeline
    localparam logic [15:0] ID_CTL      = 16'h0014;
    localparam logic [15:0] SEED        = 16'hFFFF;
    localparam logic [7:0]  K_SR        = 8'h1C;
    localparam logic [7:0]  K_BE        = 8'hFB;

    logic                   LNK_CLK_IN;
    logic                   reset;
    logic                   msg_som;
    logic                   msg_eom;
    logic                   msg_vld;
    logic [15:0]            msg_dat;
    logic [LANES-1:0]       in_k;
    logic [LANES*8-1:0]     in_dat;
    logic [LANES-1:0]       lnk_k;
    logic [LANES*8-1:0]     lnk_dat;
    logic                   lnk_sync;
    logic                   lnk_lock;

    // Case table
    int c_id [MAX_CASES];
    int c_lanes [MAX_CASES];
    int c_en [MAX_CASES];
    int c_scrm [MAX_CASES];
    int c_cnt [MAX_CASES];
    int c_be [MAX_CASES];
    int n_cases = 0;

    // Inputs and expected outputs for the next step
    logic [LANES-1:0]       nxt_k;
    logic [LANES*8-1:0]     nxt_dat;
    logic                   nxt_som;
    logic                   nxt_eom;
    logic                   nxt_vld;
    logic [15:0]            nxt_msg;
    logic [LANES-1:0]       nxt_ek;
    logic [LANES*8-1:0]     nxt_edat;
    logic                   nxt_esync;
    logic                   nxt_chk;                // Compare k and data on this step

    // Expected values in flight two deep like the DUT
    logic                   p1_v = 1'b0;
    logic                   p2_v = 1'b0;
    logic                   p1_chk;
    logic                   p2_chk;
    logic [LANES-1:0]       p1_ek;
    logic [LANES-1:0]       p2_ek;
    logic [LANES*8-1:0]     p1_edat;
    logic [LANES*8-1:0]     p2_edat;
    logic                   p1_esync;
    logic                   p2_esync;

    // Configuration the DUT should hold
    int                     cfg_lanes = 0;
    int                     cfg_en = 0;
    int                     cfg_scrm = 0;

    logic [15:0]            model_lfsr;             // Scrambler model state
    logic [31:0]            rng = 32'h7c22_8b58;
    logic                   watch_on = 1'b0;
    int                     watch_cnt;
    int                     first_lock;             // Step of first lnk_lock after SR or 0
    int                     cur_case;
    int                     errors = 0;
    int                     checks = 0;
    int                     cases_failed = 0;
    int                     cycles = 0;
    int                     cycle_limit = 0;

    dprx_lnk
    #(
        .P_LANES    (LANES)
    )
    dut_i
    (
        .LNK_CLK_IN (LNK_CLK_IN),
        .reset      (reset),
        .msg_som    (msg_som),
        .msg_eom    (msg_eom),
        .msg_vld    (msg_vld),
        .msg_dat    (msg_dat),
        .in_k       (in_k),
        .in_dat     (in_dat),
        .lnk_k      (lnk_k),
        .lnk_dat    (lnk_dat),
        .lnk_sync   (lnk_sync),
        .lnk_lock   (lnk_lock)
    );

    initial LNK_CLK_IN = 1'b0;
    always #20 LNK_CLK_IN = ~LNK_CLK_IN;           // 40 ns period

    always @(posedge LNK_CLK_IN)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // Galois step for x^16+x^5+x^4+x^3+1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic        fb;
        logic [15:0] n;
        fb   = s[15];
        n    = {s[14:0], fb};                       // x^0 term
        n[3] = s[2] ^ fb;
        n[4] = s[3] ^ fb;
        n[5] = s[4] ^ fb;
        return n;
    endfunction

    // Key byte for one symbol LSB first
    task automatic next_key(output logic [7:0] key);
        for (int i = 0; i < 8; i++)
        begin
            key[i]     = model_lfsr[15];
            model_lfsr = lfsr_step(model_lfsr);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        rng = rng * 32'd1664525 + 32'd1013904223;  // LCG
        return rng[23:16];
    endfunction

    function automatic int active_count(input int code, input int en);
        if (en == 0)
            return 0;
        case (code)
            1 : return 1;
            2 : return 2;
            3 : return 4;
            default : return 0;
        endcase
    endfunction

    task automatic report_fail(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_outputs;
        for (int l = 0; l < LANES; l++)
        begin
            if (p2_chk && (lnk_k[l] !== p2_ek[l] || lnk_dat[l*8 +: 8] !== p2_edat[l*8 +: 8]))
                report_fail($sformatf("case %0d lane %0d k %b dat %h, expected k %b dat %h",
                    cur_case, l, lnk_k[l], lnk_dat[l*8 +: 8], p2_ek[l], p2_edat[l*8 +: 8]));
        end
        if (lnk_sync !== p2_esync)
            report_fail($sformatf("case %0d lnk_sync %b, expected %b",
                cur_case, lnk_sync, p2_esync));
        checks++;
    endtask

    // Check the entry applied two falling edges ago and apply the next inputs
    task automatic drive_step;
        @(negedge LNK_CLK_IN);
        if (p2_v)
            check_outputs();
        if (watch_on)
        begin
            watch_cnt++;
            if (lnk_lock && first_lock == 0)
                first_lock = watch_cnt;
        end
        p2_v     = p1_v;
        p2_chk   = p1_chk;
        p2_ek    = p1_ek;
        p2_edat  = p1_edat;
        p2_esync = p1_esync;
        p1_v     = 1'b1;
        p1_chk   = nxt_chk;
        p1_ek    = nxt_ek;
        p1_edat  = nxt_edat;
        p1_esync = nxt_esync;
        in_k     = nxt_k;
        in_dat   = nxt_dat;
        msg_som  = nxt_som;
        msg_eom  = nxt_eom;
        msg_vld  = nxt_vld;
        msg_dat  = nxt_msg;
        nxt_som  = 1'b0;                            // Message words are one cycle
        nxt_eom  = 1'b0;
        nxt_vld  = 1'b0;
    endtask

    task automatic set_idle;
        nxt_k     = '0;
        nxt_dat   = '0;
        nxt_ek    = '0;
        nxt_edat  = '0;
        nxt_esync = 1'b0;
        nxt_chk   = 1'b0;
    endtask

    task automatic load_cases(output int ok);
        int    fd;
        int    rc;
        int    f[6];
        string line;
        ok = 0;
        fd = $fopen("lnk_cases.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd) && n_cases < MAX_CASES)
            begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0 &&
                    $sscanf(line, "%h %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5]) == 6)
                begin
                    c_id[n_cases]    = f[0];
                    c_lanes[n_cases] = f[1];
                    c_en[n_cases]    = f[2];
                    c_scrm[n_cases]  = f[3];
                    c_cnt[n_cases]   = f[4];
                    c_be[n_cases]    = f[5];
                    n_cases++;
                end
            end
            $fclose(fd);
            ok = (n_cases > 0) ? 1 : 0;
        end
    endtask

    task automatic run_case(input int idx);
        int         act;
        int         err_start;
        logic [7:0] key;
        logic [7:0] plain;
        cur_case  = idx;
        err_start = errors;
        if (c_id[idx][15:0] == ID_CTL)              // Other IDs leave the config alone
        begin
            cfg_lanes = c_lanes[idx];
            cfg_en    = c_en[idx];
            cfg_scrm  = c_scrm[idx];
        end
        act = active_count(cfg_lanes, cfg_en);

        set_idle();
        nxt_vld = 1'b1;
        nxt_som = 1'b1;
        nxt_msg = c_id[idx][15:0];
        drive_step();
        nxt_vld = 1'b1;
        nxt_eom = 1'b1;
        nxt_msg = {12'h000, c_scrm[idx][0], c_lanes[idx][1:0], c_en[idx][0]};
        drive_step();
        repeat (FLUSH) drive_step();

        // SR on every lane
        for (int l = 0; l < LANES; l++)
        begin
            nxt_k[l]          = 1'b1;
            nxt_dat[l*8 +: 8] = K_SR;
            nxt_ek[l]         = (l < act);
            nxt_edat[l*8 +: 8] = (l < act) ? K_SR : 8'h00;
        end
        nxt_chk = 1'b1;
        drive_step();
        model_lfsr = SEED;
        watch_on   = 1'b1;
        watch_cnt  = 0;
        first_lock = 0;

        for (int s = 0; s < c_cnt[idx]; s++)
        begin
            next_key(key);                          // BE also moves the LFSR
            for (int l = 0; l < LANES; l++)
            begin
                if (l == 0 && s == c_be[idx])
                begin
                    nxt_k[l]           = 1'b1;
                    nxt_dat[l*8 +: 8]  = K_BE;
                    nxt_ek[l]          = (l < act);
                    nxt_edat[l*8 +: 8] = (l < act) ? K_BE : 8'h00;
                end
                else
                begin
                    plain              = rand_byte();
                    nxt_k[l]           = 1'b0;
                    nxt_dat[l*8 +: 8]  = (cfg_scrm != 0) ? (plain ^ key) : plain;
                    nxt_ek[l]          = 1'b0;
                    nxt_edat[l*8 +: 8] = (l < act) ? plain : 8'h00;
                end
            end
            nxt_esync = (s == c_be[idx]) && (act > 0);
            drive_step();
        end
        set_idle();
        repeat (FLUSH) drive_step();
        watch_on = 1'b0;

        if (act > 0 && (first_lock == 0 || first_lock > LOCK_WINDOW))
            report_fail($sformatf("case %0d lnk_lock first seen at step %0d, expected 1 to %0d",
                idx, first_lock, LOCK_WINDOW));
        else if (act == 0 && first_lock != 0)
            report_fail($sformatf("case %0d lnk_lock high with no active lane", idx));

        if (errors != err_start)
            cases_failed++;
        $display("case %0d id %h lanes %0d scrm %0d: %s", idx, c_id[idx][15:0], act, cfg_scrm,
            (errors == err_start) ? "pass" : "fail");
    endtask

    initial
    begin
        int ok;
        reset   = 1'b1;
        msg_som = 1'b0;
        msg_eom = 1'b0;
        msg_vld = 1'b0;
        msg_dat = '0;
        in_k    = '0;
        in_dat  = '0;
        nxt_som = 1'b0;
        nxt_eom = 1'b0;
        nxt_vld = 1'b0;
        nxt_msg = '0;
        set_idle();
        load_cases(ok);
        if (ok == 0)
        begin
            $display("No test case could be read from lnk_cases.txt");
            $display("Test FAILED");
            $finish;
        end
        else
        begin
            for (int i = 0; i < n_cases; i++)
                cycle_limit += c_cnt[i] + 40;
            repeat (5) @(posedge LNK_CLK_IN);
            @(negedge LNK_CLK_IN);
            reset = 1'b0;
            for (int i = 0; i < n_cases; i++)
                run_case(i);
            $display("%0d cases: %0d passed, %0d failed, %0d checks, %0d errors",
                n_cases, n_cases - cases_failed, cases_failed, checks, errors);
            if (errors == 0)
                $display("Test OK");
            else
                $display("Test FAILED");
            $finish;
        end
    end

endmodule
